//--- hw/idct_pkg.sv
package idct_pkg;

    localparam int N_LANES    = 8;   // lanes, also the block edge
    localparam int N_COEF     = 64;
    localparam int N_WORDS    = 32;  // packed pixel pairs per block
    localparam int PROD_SHIFT = 8;
    localparam int PIX_LSB    = 16;  // pixel field of a pass-2 sum

    typedef logic signed [15:0] coef_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [7:0]         pixel_t;
    typedef logic [2:0]         idx_t;

    // one output word, seen either as a bus word or as two pixels
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            pixel_t pixel_even; // high byte
            pixel_t pixel_odd;
        } pix;
    } pixel_pair_u;

    // cosine table [k][j], scaled by 4096
    // C[7-k][j] is C[k][j] with the sign flipped on odd j
    localparam coef_t IDCT_C [N_LANES][N_LANES] = '{
        '{1448,  2009,  1892,  1703,  1448,  1138,   784,   400},
        '{1448,  1703,   784,  -400, -1448, -2009, -1892, -1138},
        '{1448,  1138,  -784, -2009, -1448,   400,  1892,  1703},
        '{1448,   400, -1892, -1138,  1448,  1703,  -784, -2009},
        '{1448,  -400, -1892,  1138,  1448, -1703,  -784,  2009},
        '{1448, -1138,  -784,  2009, -1448,  -400,  1892, -1703},
        '{1448, -1703,   784,   400, -1448,  2009, -1892,  1138},
        '{1448, -2009,  1892, -1703,  1448, -1138,   784,  -400}
    };

endpackage

//--- hw/idct_lane_if.sv
`timescale 1ns/1ps

// operand beats from the feeder to all eight lanes, no back-pressure
interface lane_beat_if import idct_pkg::*; ();

    logic  beat_valid;
    logic  first;       // start of a sum
    logic  last;        // end of a sum
    logic  final_pass;  // high during pass 2
    acc_t  operand_a [N_LANES];
    coef_t operand_b [N_LANES];

    modport feeder (output beat_valid, first, last, final_pass, operand_a, operand_b);
    modport lane   (input  beat_valid, first, last, final_pass, operand_a, operand_b);

endinterface

// finished sums from the lanes
interface lane_result_if import idct_pkg::*; ();

    logic result_valid; // from lane 0
    logic final_pass;   // from lane 0
    acc_t result [N_LANES];
    logic row_ready;    // packer holds no row

    modport lane   (output result_valid, final_pass, result);
    modport feeder (input result_valid, final_pass, result, row_ready);
    modport packer (input result_valid, final_pass, result, output row_ready);

endinterface

//--- hw/operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder import idct_pkg::*; (
    input  logic  CLOCK,
    input  logic  Resetn,
    input  logic  in_valid,
    output logic  in_ready,
    input  coef_t in_coef,
    lane_beat_if.feeder   beat,
    lane_result_if.feeder res
);

    localparam logic [1:0] PH_LOAD  = 2'd0;
    localparam logic [1:0] PH_PASS1 = 2'd1;
    localparam logic [1:0] PH_GAP   = 2'd2;
    localparam logic [1:0] PH_PASS2 = 2'd3;

    localparam idx_t LAST_IDX = idx_t'(N_LANES - 1);

    logic [1:0] phase_q;
    logic [5:0] load_cnt;  // row-major coefficient index
    idx_t       row_q;
    idx_t       k_q;
    idx_t       t_row_q;   // next T row to store
    logic       t_store;

    coef_t s_buf [N_COEF];           // S' block
    acc_t  t_buf [N_LANES][N_LANES]; // T = S'C, [row][col]

    assign in_ready = (phase_q == PH_LOAD);

    // pass-1 sums come back here, pass-2 sums go to the packer
    assign t_store = res.result_valid && !res.final_pass;

    // a pass-2 row only starts when the packer can take it
    assign beat.beat_valid = (phase_q == PH_PASS1) ||
                             ((phase_q == PH_PASS2) && ((k_q != '0) || res.row_ready));
    assign beat.first      = (k_q == '0);
    assign beat.last       = (k_q == LAST_IDX);
    assign beat.final_pass = (phase_q == PH_PASS2);

    always_comb begin
        for (int j = 0; j < N_LANES; j++) begin
            if (phase_q == PH_PASS2) begin
                beat.operand_a[j] = t_buf[k_q][j];    // T[k][j]
                beat.operand_b[j] = IDCT_C[k_q][row_q]; // C transposed
            end else begin
                beat.operand_a[j] = s_buf[{row_q, k_q}]; // S'[r][k] to every lane
                beat.operand_b[j] = IDCT_C[k_q][j];
            end
        end
    end

    always_ff @(posedge CLOCK) begin
        if (in_valid && in_ready) begin
            s_buf[load_cnt] <= in_coef;
        end
        if (t_store) begin
            t_buf[t_row_q] <= res.result;
        end
    end

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            phase_q  <= PH_LOAD;
            load_cnt <= '0;
            row_q    <= '0;
            k_q      <= '0;
            t_row_q  <= '0;
        end else begin
            if (t_store) begin
                t_row_q <= t_row_q + 1'b1; // wraps back to row 0 after row 7
            end

            case (phase_q)
                PH_LOAD: begin
                    if (in_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == 6'(N_COEF - 1)) begin
                            phase_q <= PH_PASS1;
                        end
                    end
                end

                PH_PASS1, PH_PASS2: begin
                    if (beat.beat_valid) begin
                        k_q <= k_q + 1'b1;
                        if (beat.last) begin
                            row_q <= row_q + 1'b1;
                            if (row_q == LAST_IDX) begin
                                phase_q <= (phase_q == PH_PASS1) ? PH_GAP : PH_LOAD;
                            end
                        end
                    end
                end

                // wait for T row 7 to land before reading columns of T
                PH_GAP: begin
                    if (t_store && (t_row_q == LAST_IDX)) begin
                        phase_q <= PH_PASS2;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/mac_lane.sv
`timescale 1ns/1ps

module mac_lane import idct_pkg::*; (
    input  logic CLOCK,
    input  logic Resetn,
    input  idx_t lane_idx,
    lane_beat_if.lane   beat,
    lane_result_if.lane res
);

    logic signed [47:0] prod_full;
    acc_t               prod_scaled;
    acc_t               acc_q;
    acc_t               sum_next;

    assign prod_full   = beat.operand_a[lane_idx] * beat.operand_b[lane_idx];
    assign prod_scaled = acc_t'(prod_full >>> PROD_SHIFT); // keep low 32 bits
    assign sum_next    = beat.first ? prod_scaled : acc_q + prod_scaled;

    // result slot is separate so the next sum can start right away
    always_ff @(posedge CLOCK) begin
        if (beat.beat_valid) begin
            acc_q <= sum_next;
        end
        if (beat.beat_valid && beat.last) begin
            res.result[lane_idx] <= sum_next;
            if (lane_idx == '0) begin
                res.final_pass <= beat.final_pass;
            end
        end
    end

    // lanes run in step, so lane 0 flags the whole row
    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            res.result_valid <= 1'b0;
        end else if (lane_idx == '0) begin
            res.result_valid <= beat.beat_valid && beat.last; // one cycle pulse
        end
    end

endmodule

//--- hw/clip_packer.sv
`timescale 1ns/1ps

module clip_packer import idct_pkg::*; (
    input  logic        CLOCK,
    input  logic        Resetn,
    lane_result_if.packer res,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [15:0] out_pair
);

    localparam int ROW_WORDS = N_WORDS / N_LANES; // 4 pairs per row

    pixel_t      row_q [N_LANES];
    logic        full_q;
    logic [1:0]  word_q;
    logic        capture;
    pixel_pair_u pair;

    // negative -> 0, overflow above the pixel field -> 255
    function automatic pixel_t clip_pixel(input acc_t sum);
        if (sum[31]) begin
            return '0;
        end else if (|sum[30:PIX_LSB+8]) begin
            return 8'hff;
        end
        return sum[PIX_LSB +: 8];
    endfunction

    assign capture = res.result_valid && res.final_pass;

    // also low while a row is arriving, so no second row is started behind it
    assign res.row_ready = !full_q && !capture;

    assign out_valid            = full_q;
    assign pair.pix.pixel_even  = row_q[{word_q, 1'b0}];
    assign pair.pix.pixel_odd   = row_q[{word_q, 1'b1}];
    assign out_pair             = pair.raw;

    always_ff @(posedge CLOCK) begin
        if (capture) begin
            for (int j = 0; j < N_LANES; j++) begin
                row_q[j] <= clip_pixel(res.result[j]);
            end
        end
    end

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            full_q <= 1'b0;
            word_q <= '0;
        end else if (capture) begin
            full_q <= 1'b1;
            word_q <= '0;
        end else if (full_q && out_ready) begin
            word_q <= word_q + 1'b1;
            if (word_q == 2'(ROW_WORDS - 1)) begin
                full_q <= 1'b0; // last pair of the row taken
            end
        end
    end

endmodule

//--- hw/idct_block.sv
`timescale 1ns/1ps

module idct_block import idct_pkg::*; (
    input  logic        CLOCK,
    input  logic        Resetn,
    input  logic        in_valid,
    output logic        in_ready,
    input  coef_t       in_coef,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [15:0] out_pair
);

    lane_beat_if   beat_if ();
    lane_result_if res_if ();

    operand_feeder feeder_i (
        .CLOCK    (CLOCK),
        .Resetn   (Resetn),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_coef  (in_coef),
        .beat     (beat_if.feeder),
        .res      (res_if.feeder)
    );

    // one lane per output column
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        mac_lane lane_i (
            .CLOCK    (CLOCK),
            .Resetn   (Resetn),
            .lane_idx (idx_t'(g)),
            .beat     (beat_if.lane),
            .res      (res_if.lane)
        );
    end

    clip_packer packer_i (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .res       (res_if.packer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pair  (out_pair)
    );

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic CLOCK,
    output logic Resetn
);

    localparam int RESET_CYCLES = 16;

    initial begin
        CLOCK = 1'b0;
        forever #50 CLOCK = ~CLOCK; // 100 ns period
    end

    initial begin
        Resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK);
        @(negedge CLOCK);
        Resetn = 1'b1; // released away from the active edge
    end

endmodule

//--- dv/idct_tb.sv
`timescale 1ns/1ps

module idct_tb import idct_pkg::*; ();

    // 13 blocks of about 200 cycles, doubled for back-pressure, plus margin
    localparam int CYCLE_LIMIT = 8000;

    logic        CLOCK;
    logic        Resetn;
    logic        in_valid;
    logic        in_ready;
    coef_t       in_coef;
    logic        out_valid;
    logic        out_ready;
    logic [15:0] out_pair;

    pixel_pair_u exp_q [$];        // expected words, oldest first
    logic        random_ready = 1'b0;
    logic        overlap_seen = 1'b0; // load accepted while output was draining
    int          words_seen   = 0;
    int          cycle_cnt    = 0;

    clock_gen clock_gen_i (
        .CLOCK  (CLOCK),
        .Resetn (Resetn)
    );

    idct_block idct_block_i (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_coef   (in_coef),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pair  (out_pair)
    );

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_pair(input pixel_pair_u expected, input pixel_pair_u actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: out_pair expected %h got %h",
                     $time, expected.raw, actual.raw);
            stop_with_failure();
        end
    endtask

    // product scaled by 2^-8, kept to 32 bits
    function automatic acc_t scaled_product(input acc_t a, input coef_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return acc_t'(p >>> PROD_SHIFT);
    endfunction

    function automatic pixel_t to_pixel(input acc_t s);
        if (s < 0) begin
            return 8'd0;
        end
        if (s >= 32'sh0100_0000) begin
            return 8'd255; // above the 8-bit field
        end
        return pixel_t'(s >> 16);
    endfunction

    // T = S'C, then S = C'T, clipped and packed two pixels per word
    function automatic void idct_ref(input coef_t blk [N_COEF],
                                     output pixel_pair_u words [N_WORDS]);
        acc_t   t [N_LANES][N_LANES];
        acc_t   s;
        pixel_t pix [N_LANES];
        for (int r = 0; r < N_LANES; r++) begin
            for (int j = 0; j < N_LANES; j++) begin
                t[r][j] = '0;
                for (int k = 0; k < N_LANES; k++) begin
                    t[r][j] = t[r][j] + scaled_product(acc_t'(blk[r * N_LANES + k]),
                                                       IDCT_C[k][j]);
                end
            end
        end
        for (int r = 0; r < N_LANES; r++) begin
            for (int j = 0; j < N_LANES; j++) begin
                s = '0;
                for (int k = 0; k < N_LANES; k++) begin
                    s = s + scaled_product(t[k][j], IDCT_C[k][r]);
                end
                pix[j] = to_pixel(s);
            end
            for (int w = 0; w < N_LANES / 2; w++) begin
                words[r * 4 + w].raw = {pix[2 * w], pix[2 * w + 1]}; // even pixel high
            end
        end
    endfunction

    function automatic void random_block(output coef_t blk [N_COEF], input int span);
        for (int i = 0; i < N_COEF; i++) begin
            blk[i] = coef_t'(int'($urandom_range(2 * span, 0)) - span);
        end
    endfunction

    // called on a falling edge, returns on the falling edge after the last transfer
    task automatic send_block(input coef_t blk [N_COEF]);
        pixel_pair_u words [N_WORDS];
        int          i;
        logic        accepted;
        idct_ref(blk, words);
        for (int w = 0; w < N_WORDS; w++) begin
            exp_q.push_back(words[w]);
        end
        i        = 0;
        in_valid = 1'b1;
        in_coef  = blk[0];
        while (i < N_COEF) begin
            accepted = in_ready; // only changes on the rising edge
            if (accepted && out_valid) begin
                overlap_seen = 1'b1;
            end
            @(negedge CLOCK);
            if (accepted) begin
                i++;
                if (i < N_COEF) begin
                    in_coef = blk[i];
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge CLOCK);
    endtask

    task automatic wait_drained();
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge CLOCK);
        end
        repeat (16) @(negedge CLOCK); // catch any extra word
    endtask

    // drives out_ready and checks every word taken on the next rising edge
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge CLOCK);
            if (random_ready) begin
                out_ready = ($urandom_range(1, 0) == 1);
            end else begin
                out_ready = 1'b1;
            end
            if (Resetn && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output word %h at %0t arrived with no block outstanding",
                             out_pair, $time);
                    stop_with_failure();
                end else begin
                    compare_pair(exp_q.pop_front(), pixel_pair_u'(out_pair));
                    words_seen++;
                end
            end
        end
    end

    always @(posedge CLOCK) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("cycle limit %0d reached, output stalled with %0d words still expected",
                     CYCLE_LIMIT, exp_q.size());
            stop_with_failure();
        end
    end

    initial begin
        coef_t blk [N_COEF];
        void'($urandom(79));
        in_valid = 1'b0;
        in_coef  = '0;
        @(posedge Resetn);
        @(negedge CLOCK);

        // DC only
        foreach (blk[i]) blk[i] = '0;
        blk[0] = 16'sd3000;
        send_block(blk);
        idle(4);

        // small random coefficients
        repeat (2) begin
            random_block(blk, 256);
            send_block(blk);
        end
        idle(4);

        // saturation both ways
        foreach (blk[i]) blk[i] = 16'sh7fff;
        send_block(blk);
        foreach (blk[i]) blk[i] = 16'sh8000;
        send_block(blk);
        wait_drained();

        random_ready = 1'b1; // out_ready low about half the time
        repeat (3) begin
            random_block(blk, 256);
            send_block(blk);
        end
        wait_drained();
        random_ready = 1'b0;

        overlap_seen = 1'b0;
        repeat (5) begin
            random_block(blk, 256);
            send_block(blk);
        end
        wait_drained();

        $display("%0d words checked in %0d cycles", words_seen, cycle_cnt);
        if (!overlap_seen) begin
            $display("next block was never accepted while the previous block drained");
            stop_with_failure();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/idct_pkg.sv
hw/idct_lane_if.sv
hw/operand_feeder.sv
hw/mac_lane.sv
hw/clip_packer.sv
hw/idct_block.sv
dv/clock_gen.sv
dv/idct_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the IDCT testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module idct_tb \
    -f filelist.f \
    --Mdir obj_dir -o idct_sim

# a $fatal exits non-zero, so the log is searched instead
./obj_dir/idct_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log
